//--- hdl/decodePkg.sv
// Shared types and helpers for the register-specifier decode stage.
// Register numbers are 9 bits. Field values are 6 bits and a regx bit adds 64.
// Field value 63 is the stack pointer and is renamed per operating mode.
// Opcode encodings cover only the subset this stage needs to tell apart.
`default_nettype none

package decodePkg;

	// ========================================
	// Enumerations
	// ========================================

	// Instruction and postfix opcodes, 7 bits wide
	typedef enum logic [6:0] {
		OP_R2    = 7'h02,
		OP_ADDI  = 7'h04,
		OP_SHIFT = 7'h10,
		OP_LDO   = 7'h4B,
		OP_STB   = 7'h50,
		OP_STW   = 7'h51,
		OP_STT   = 7'h52,
		OP_STO   = 7'h53,
		OP_REGC  = 7'h7A,
		OP_IMMC  = 7'h7B,
		OP_NOP   = 7'h7F
	} opcode_t;

	// The order matters since the mode is added to the stack-pointer base
	typedef enum logic [1:0] {
		MODE_USER    = 2'd0,
		MODE_SUPER   = 2'd1,
		MODE_HYPER   = 2'd2,
		MODE_MACHINE = 2'd3
	} operating_mode_t;

	typedef logic [8:0] aregno_t;

	// ========================================
	// Instruction word and stage structs
	// ========================================

	typedef struct packed {
		logic       spare;
		logic [5:0] rc;
		logic [5:0] rb;
		logic [5:0] ra;
		logic [5:0] rt;
		opcode_t    opcode;
	} instr_t;

	// Window of two words, where ins1 may be a postfix of ins0
	typedef struct packed {
		instr_t          ins0;
		instr_t          ins1;
		logic [3:0]      regx;
		operating_mode_t om;
	} decodeIn_t;

	typedef struct packed {
		aregno_t     ra;
		aregno_t     rb;
		aregno_t     rc;
		aregno_t     rt;
		logic [2:0]  rcc;
		logic        rtWe;
		logic        hasImmc;
		logic [31:0] immc;
		logic        usedPostfix;
	} decodeOut_t;

	// ========================================
	// Helper functions
	// ========================================

	function automatic logic isStore(input opcode_t op);
		return op inside {OP_STB, OP_STW, OP_STT, OP_STO};
	endfunction

	// Opcodes whose C field holds immediate bits rather than a register
	function automatic logic fnImmc(input opcode_t op);
		return op inside {OP_ADDI, OP_LDO, OP_NOP};
	endfunction

	// A set regx bit selects the upper bank, which is the field plus 64
	function automatic aregno_t extReg(input logic [5:0] field, input logic bank);
		return {2'b00, bank, field};
	endfunction

	// Stack pointer gets one physical copy per operating mode
	function automatic aregno_t mapSp(input aregno_t r, input aregno_t base,
		input operating_mode_t om);
		if (r == 9'd63)
			return base + {7'd0, om};
		return r;
	endfunction

endpackage

`default_nettype wire

//--- hdl/decodeImm.sv
// Immediate-C postfix detection.
// Only ins1 is examined. Its bits 31 to 7 form a signed 25-bit payload.
// Without the postfix, immc is forced to zero.
`timescale 1ns/1ns
`default_nettype none

module decodeImm import decodePkg::*; (
	input  decodeIn_t   inData,
	output logic        hasImmc,
	output logic [31:0] immc
);

	logic [24:0] payload;

	// The postfix payload sits above the opcode and fills the rest of the word
	assign payload = inData.ins1[31:7];

	always_comb begin
		hasImmc = 1'b0;
		immc = 32'd0;
		if (inData.ins1.opcode == OP_IMMC) begin
			hasImmc = 1'b1;
			// Replicate the payload's top bit into the upper seven bits
			immc = {{7{payload[24]}}, payload};
		end
	end

endmodule

`default_nettype wire

//--- hdl/decodeRaRb.sv
// Ra and Rb source-register decode.
// Ra uses regx bit 1 and Rb uses regx bit 2 to reach the upper bank.
// ADDI and LDO carry immediate bits in the B field, so Rb is 0 for them.
// SpBase must leave room for four stack pointers below 512.
`timescale 1ns/1ns
`default_nettype none

module decodeRaRb import decodePkg::*; #(
	parameter int SpBase = 65
) (
	input  decodeIn_t inData,
	output aregno_t   ra,
	output aregno_t   rb
);

	localparam aregno_t SpBaseReg = aregno_t'(SpBase);

	aregno_t raExt;
	aregno_t rbExt;

	// Bank extension comes first, then the stack-pointer rename
	always_comb begin
		raExt = extReg(inData.ins0.ra, inData.regx[1]);
		rbExt = extReg(inData.ins0.rb, inData.regx[2]);
		// B field is part of the immediate for these two
		if (inData.ins0.opcode inside {OP_ADDI, OP_LDO})
			rbExt = 9'd0;
	end

	// Register 0 never equals 63, so a cleared Rb stays cleared
	always_comb begin
		ra = mapSp(raExt, SpBaseReg, inData.om);
		rb = mapSp(rbExt, SpBaseReg, inData.om);
	end

endmodule

`default_nettype wire

//--- hdl/decodeRc.sv
// Rc source-register and condition-code decode.
// hasImmc comes from decodeImm. A REGC postfix in ins1 overrides Rc and Rcc.
// The REGC register is taken without bank extension.
// REGC and IMMC never occur together since only one postfix word exists.
`timescale 1ns/1ns
`default_nettype none

module decodeRc import decodePkg::*; #(
	parameter int SpBase = 65
) (
	input  decodeIn_t  inData,
	input  logic       hasImmc,
	output aregno_t    rc,
	output logic [2:0] rcc
);

	localparam aregno_t SpBaseReg = aregno_t'(SpBase);

	aregno_t rcSel;

	always_comb begin
		rcSel = 9'd0;
		rcc = 3'd0;
		// An immediate C operand leaves no register to read
		if (hasImmc)
			rcSel = 9'd0;
		// Stores read their data register from the Rt field
		else if (isStore(inData.ins0.opcode))
			rcSel = extReg(inData.ins0.rt, inData.regx[0]);
		else if (inData.ins0.opcode inside {OP_R2, OP_SHIFT})
			rcSel = extReg(inData.ins0.rc, inData.regx[3]);
		else if (fnImmc(inData.ins0.opcode))
			rcSel = 9'd0;
		else
			rcSel = extReg(inData.ins0.rc, inData.regx[3]);

		// Postfix override, condition code lives in bits 15 to 13 of the postfix
		if (inData.ins1.opcode == OP_REGC) begin
			rcSel = {3'b000, inData.ins1.rt};
			rcc = inData.ins1[15:13];
		end
	end

	// Stack-pointer rename applies to whichever source won above
	assign rc = mapSp(rcSel, SpBaseReg, inData.om);

endmodule

`default_nettype wire

//--- hdl/decodeRt.sv
// Target-register decode.
// Stores and NOP write nothing. Register 0 is constant so it is never written.
// The Rt field uses regx bit 0 for the upper bank.
`timescale 1ns/1ns
`default_nettype none

module decodeRt import decodePkg::*; #(
	parameter int SpBase = 65
) (
	input  decodeIn_t inData,
	output aregno_t   rt,
	output logic      rtWe
);

	localparam aregno_t SpBaseReg = aregno_t'(SpBase);

	logic noTarget;

	// For stores the Rt field names the data source, handled by decodeRc
	assign noTarget = isStore(inData.ins0.opcode) || (inData.ins0.opcode == OP_NOP);

	always_comb begin
		if (noTarget) begin
			rt = 9'd0;
		end else begin
			rt = mapSp(extReg(inData.ins0.rt, inData.regx[0]), SpBaseReg, inData.om);
		end
	end

	// A mapped stack pointer is never zero, so only a true R0 target loses its write
	assign rtWe = !noTarget && (rt != 9'd0);

endmodule

`default_nettype wire

//--- hdl/decodeStage.sv
// Register-specifier decode stage with valid/ready on both sides.
// One cycle of latency, at most one item held in the output register.
// A full output being drained in the same cycle can accept a new item.
// The decoders are purely combinational and see inData directly.
// SpBase is passed down unchanged to the three register decoders.
`timescale 1ns/1ns
`default_nettype none

module decodeStage import decodePkg::*; #(
	parameter int SpBase = 65
) (
	input  logic       clk,
	input  logic       rstN,
	input  logic       inValid,
	output logic       inReady,
	input  decodeIn_t  inData,
	output logic       outValid,
	input  logic       outReady,
	output decodeOut_t outData
);

	// ========================================
	// Combinational decode
	// ========================================

	decodeOut_t nextOut;
	logic inFire;

	decodeImm u_decodeImm (
		.inData  (inData),
		.hasImmc (nextOut.hasImmc),
		.immc    (nextOut.immc)
	);

	decodeRaRb #(.SpBase(SpBase)) u_decodeRaRb (
		.inData (inData),
		.ra     (nextOut.ra),
		.rb     (nextOut.rb)
	);

	// Rc depends on the immediate detection, so hasImmc is fed across
	decodeRc #(.SpBase(SpBase)) u_decodeRc (
		.inData  (inData),
		.hasImmc (nextOut.hasImmc),
		.rc      (nextOut.rc),
		.rcc     (nextOut.rcc)
	);

	decodeRt #(.SpBase(SpBase)) u_decodeRt (
		.inData (inData),
		.rt     (nextOut.rt),
		.rtWe   (nextOut.rtWe)
	);

	// Tells fetch that ins1 was consumed as part of this instruction
	assign nextOut.usedPostfix = (inData.ins1.opcode == OP_REGC) ||
		(inData.ins1.opcode == OP_IMMC);

	// ========================================
	// Handshake and output register
	// ========================================

	// Room exists when the output is empty or leaving this cycle
	assign inReady = !outValid || outReady;
	assign inFire = inValid && inReady;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			outValid <= 1'b0;
			outData <= '0;
		end else begin
			if (inFire) begin
				outValid <= 1'b1;
				outData <= nextOut;
			end else if (outReady) begin
				// Drained with nothing new, data simply holds its last value
				outValid <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- verif/decodeRef.svh
// Expected decode result, built from the field and postfix rules alone.
// Assumes ins0 holds one of the defined instruction opcodes.
// Included inside the testbench module, which imports the decode package.
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// A set bank bit moves the field into the upper bank, 64 registers up
function automatic aregno_t bankReg(input logic [5:0] field, input logic bank);
	aregno_t r;
	r = {3'b000, field};
	if (bank)
		r = r + 9'd64;
	return r;
endfunction

// Register 63 is the stack pointer, with one copy for each mode
function automatic aregno_t spRename(input aregno_t r, input operating_mode_t om,
	input int base);
	if (r == 9'd63)
		return aregno_t'(base) + aregno_t'(om);
	return r;
endfunction

function automatic decodeOut_t decodeRef(input decodeIn_t d, input int base);
	decodeOut_t e;
	opcode_t op0;
	opcode_t op1;
	logic store;
	logic immFmt;
	aregno_t rcRaw;
	e = '0;
	op0 = d.ins0.opcode;
	op1 = d.ins1.opcode;
	store = (op0 == OP_STB) || (op0 == OP_STW) || (op0 == OP_STT) || (op0 == OP_STO);
	// ADDI and LDO spend the B and C fields on immediate bits
	immFmt = (op0 == OP_ADDI) || (op0 == OP_LDO);

	e.ra = spRename(bankReg(d.ins0.ra, d.regx[1]), d.om, base);
	if (!immFmt)
		e.rb = spRename(bankReg(d.ins0.rb, d.regx[2]), d.om, base);

	e.hasImmc = (op1 == OP_IMMC);
	if (e.hasImmc)
		e.immc = {{7{d.ins1[31]}}, d.ins1[31:7]};

	rcRaw = 9'd0;
	if (e.hasImmc)
		rcRaw = 9'd0;
	else if (store)
		rcRaw = bankReg(d.ins0.rt, d.regx[0]);
	else if (!immFmt && op0 != OP_NOP)
		rcRaw = bankReg(d.ins0.rc, d.regx[3]);
	// REGC postfix wins, its register has no bank bit
	if (op1 == OP_REGC) begin
		rcRaw = {3'b000, d.ins1.rt};
		e.rcc = d.ins1[15:13];
	end
	e.rc = spRename(rcRaw, d.om, base);

	if (!store && op0 != OP_NOP) begin
		e.rt = spRename(bankReg(d.ins0.rt, d.regx[0]), d.om, base);
		e.rtWe = (e.rt != 9'd0);
	end
	e.usedPostfix = (op1 == OP_REGC) || (op1 == OP_IMMC);
	return e;
endfunction

`endif

//--- verif/decodeStageTb.sv
// Testbench for the decode stage with random items and random output stalls.
// Inputs change on the falling edge, transfers are sampled at the rising edge.
// The DUT runs with its default SpBase, which the reference assumes is 65.
`timescale 1ns/1ns
`default_nettype none

module decodeStageTb import decodePkg::*; ();

	`include "decodeRef.svh"

	localparam int SpBase = 65;
	localparam int NumItems = 2000;
	// Under four cycles per item even with idle inputs and stalled outputs
	localparam int TimeoutCycles = 4 * NumItems + 100;

	logic clk;
	logic rstN;
	logic inValid;
	logic inReady;
	decodeIn_t inData;
	logic outValid;
	logic outReady;
	decodeOut_t outData;

	integer seed;
	int issued;
	int accepted;
	int checked;
	int cycles;
	logic fired;
	decodeOut_t expQ[$];

	decodeStage u_decodeStage (
		.clk      (clk),
		.rstN     (rstN),
		.inValid  (inValid),
		.inReady  (inReady),
		.inData   (inData),
		.outValid (outValid),
		.outReady (outReady),
		.outData  (outData)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// ========================================
	// Compare tasks
	// ========================================

	task automatic checkReg(input string name, input aregno_t exp, input aregno_t act);
		if (act !== exp) begin
			$display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, exp, act);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	task automatic checkBits(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	task automatic checkFlag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[FAIL] t=%0t %s expected %b got %b", $time, name, exp, act);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	task automatic compareOut(input decodeOut_t want, input decodeOut_t got);
		checkReg("ra", want.ra, got.ra);
		checkReg("rb", want.rb, got.rb);
		checkReg("rc", want.rc, got.rc);
		checkReg("rt", want.rt, got.rt);
		checkBits("rcc", {29'd0, want.rcc}, {29'd0, got.rcc});
		checkBits("immc", want.immc, got.immc);
		checkFlag("rtWe", want.rtWe, got.rtWe);
		checkFlag("hasImmc", want.hasImmc, got.hasImmc);
		checkFlag("usedPostfix", want.usedPostfix, got.usedPostfix);
	endtask

	// ========================================
	// Random stimulus
	// ========================================

	function automatic logic [31:0] randWord();
		return $random(seed);
	endfunction

	// Stack pointer and register 0 come up far more often than by chance
	function automatic logic [5:0] randField();
		logic [31:0] r;
		r = randWord();
		if (r[31:30] == 2'b00)
			return 6'd63;
		if (r[31:28] == 4'b0100)
			return 6'd0;
		return r[5:0];
	endfunction

	function automatic opcode_t randInstrOp();
		logic [31:0] r;
		r = randWord();
		case (r % 32'd9)
			32'd0: return OP_R2;
			32'd1: return OP_SHIFT;
			32'd2: return OP_ADDI;
			32'd3: return OP_LDO;
			32'd4: return OP_STB;
			32'd5: return OP_STW;
			32'd6: return OP_STT;
			32'd7: return OP_STO;
			default: return OP_NOP;
		endcase
	endfunction

	// Second word is REGC or IMMC in about three quarters of items
	function automatic decodeIn_t makeItem();
		decodeIn_t d;
		logic [31:0] r;
		r = randWord();
		d.ins0.spare = r[0];
		d.ins0.rc = randField();
		d.ins0.rb = randField();
		d.ins0.ra = randField();
		d.ins0.rt = randField();
		d.ins0.opcode = randInstrOp();
		d.ins1 = randWord();
		d.ins1.rt = randField();
		if (r[9:8] == 2'b00)
			d.ins1.opcode = randInstrOp();
		else
			d.ins1.opcode = r[10] ? OP_REGC : OP_IMMC;
		d.regx = r[4:1];
		d.om = operating_mode_t'(r[6:5]);
		return d;
	endfunction

	// ========================================
	// Scoreboard and timeout
	// ========================================

	// Reads here see the values from before this edge, as the DUT does
	always @(posedge clk) begin : scoreboard
		decodeOut_t want;
		if (rstN) begin
			// At most one item is in flight, so the queue depth is the output occupancy
			checkFlag("outValid", expQ.size() != 0, outValid);
			checkFlag("inReady", (expQ.size() == 0) || outReady, inReady);
			if (outValid && outReady) begin
				if (expQ.size() == 0) begin
					$display("Output transfer at t=%0t with no item expected", $time);
					$display("Something failed");
					$fatal(1);
				end
				want = expQ.pop_front();
				compareOut(want, outData);
				checked++;
			end
			fired = inValid && inReady;
			if (fired) begin
				expQ.push_back(decodeRef(inData, SpBase));
				accepted++;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > TimeoutCycles) begin
			$display("Timeout after %0d cycles with %0d of %0d items checked",
				cycles, checked, NumItems);
			$display("Something failed");
			$fatal(1);
		end
	end

	initial begin : stimulus
		logic [31:0] r;
		seed = 32'hced3_646e;
		rstN = 1'b0;
		inValid = 1'b0;
		inData = '0;
		outReady = 1'b0;
		fired = 1'b0;
		issued = 0;
		accepted = 0;
		checked = 0;
		cycles = 0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		checkFlag("outValid", 1'b0, outValid);
		checkFlag("inReady", 1'b1, inReady);
		checkFlag("outData is zero", 1'b1, outData == '0);
		rstN = 1'b1;
		while (checked < NumItems) begin
			@(negedge clk);
			r = randWord();
			// Roughly 30 percent of cycles stall the output
			outReady = (r % 32'd100) >= 32'd30;
			// A new item only once the held one was taken
			if (!inValid || fired) begin
				if (issued < NumItems && r[19:16] != 4'd0) begin
					inData = makeItem();
					inValid = 1'b1;
					issued++;
				end else begin
					inValid = 1'b0;
				end
			end
		end
		inValid = 1'b0;
		if (expQ.size() == 0 && accepted == NumItems) begin
			$display("Everything OK");
			$finish;
		end else begin
			$display("%0d items left over after %0d were checked", expQ.size(), checked);
			$display("Something failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+verif
hdl/decodePkg.sv
hdl/decodeImm.sv
hdl/decodeRaRb.sv
hdl/decodeRc.sv
hdl/decodeRt.sv
hdl/decodeStage.sv
verif/decodeStageTb.sv

//--- run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f filelist.f --top-module decodeStageTb \
	&& ./obj_dir/VdecodeStageTb > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q "^Everything OK$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
